// File: filelist.f
+incdir+verilog
verilog/or32_isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/insn_pipe.sv
verilog/if_predecode.sv
verilog/imm_extend.sv
verilog/operand_select.sv
verilog/ex_decode.sv
verilog/decode_ctrl.sv
tests/decode_ctrl_sva.sv
tests/decode_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build the decode control testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f filelist.f \
	--top-module decode_ctrl_tb \
	-o decode_ctrl_sim

out=$(./obj_dir/decode_ctrl_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "^Result: PASSED$"; then
	exit 0
else
	exit 1
fi

// File: tests/decode_ctrl_sva.sv
////////////////////////////////////////
// flush, bubble and reset properties
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "decode_config.svh"

module decode_ctrl_sva (
	input wire logic clk,
	input wire logic reset,
	input wire logic flushpipe,
	input wire logic ex_bubble,
	input wire or32_isa_pkg::insn_t id_insn,
	input wire or32_isa_pkg::insn_t ex_insn,
	input wire or32_isa_pkg::insn_t wb_insn,
	input wire ctrl_pkg::branch_op_e id_branch_op,
	input wire ctrl_pkg::branch_op_e ex_branch_op,
	input wire ctrl_pkg::alu_op_t alu_op,
	input wire ctrl_pkg::rfwb_op_t rfwb_op,
	input wire logic except_illegal,
	input wire logic sig_syscall,
	input wire logic sig_trap
);

	// a flush puts a nop into ID
	flush_to_id_nop: assert property (@(posedge clk) disable iff (reset)
		flushpipe |=> (id_insn == `NOP_INSN))
		else $error("id_insn is not a nop one cycle after a flush");

	// a bubble empties EX and stops its writeback
	bubble_to_ex_nop: assert property (@(posedge clk) disable iff (reset)
		ex_bubble |=> ((ex_insn == `NOP_INSN) && (rfwb_op == ctrl_pkg::RFWB_NOP)))
		else $error("EX stage not emptied one cycle after a bubble");

	// everything idle right out of reset
	reset_idle: assert property (@(posedge clk)
		reset |=> ((id_branch_op == ctrl_pkg::BR_NOP) && (ex_branch_op == ctrl_pkg::BR_NOP)
			&& (alu_op == ctrl_pkg::ALUOP_NOP) && (rfwb_op == ctrl_pkg::RFWB_NOP)
			&& !except_illegal && !sig_syscall && !sig_trap
			&& (id_insn == `NOP_INSN) && (ex_insn == `NOP_INSN) && (wb_insn == `NOP_INSN)))
		else $error("control outputs active after a reset cycle");

endmodule

`default_nettype wire

// File: tests/decode_ctrl_tb.sv
////////////////////////////////////////
// random decode traffic against a cycle model
// freezes drawn nested with rare flushes and breakpoints
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "decode_config.svh"

module decode_ctrl_tb;

	localparam int RUN_CYCLES = 3000;
	localparam int SEED = 31478;

	// DUT inputs
	logic clk;
	logic reset;
	logic id_freeze;
	logic ex_freeze;
	logic wb_freeze;
	logic except_flushpipe;
	logic pc_we;
	logic extend_flush;
	logic du_flush_pipe;
	or32_isa_pkg::insn_t if_insn;
	logic wbforw_valid;
	logic du_hwbkpt;
	logic ex_branch_taken;

	// DUT outputs
	or32_isa_pkg::insn_t id_insn;
	or32_isa_pkg::insn_t ex_insn;
	or32_isa_pkg::insn_t wb_insn;
	or32_isa_pkg::imm_t id_simm;
	or32_isa_pkg::imm_t ex_simm;
	or32_isa_pkg::rf_addr_t rf_addra;
	or32_isa_pkg::rf_addr_t rf_addrb;
	or32_isa_pkg::rf_addr_t rf_addrw;
	logic rf_rda;
	logic rf_rdb;
	ctrl_pkg::sel_e sel_a;
	ctrl_pkg::sel_e sel_b;
	ctrl_pkg::branch_op_e id_branch_op;
	ctrl_pkg::branch_op_e ex_branch_op;
	ctrl_pkg::alu_op_t alu_op;
	ctrl_pkg::alu_op2_t alu_op2;
	ctrl_pkg::comp_op_t comp_op;
	ctrl_pkg::rfwb_op_t rfwb_op;
	logic except_illegal;
	logic sig_syscall;
	logic sig_trap;
	logic rfe;
	logic flushpipe;

	int error_count;

	////////////////////////////////////////
	// model state for each DUT register
	////////////////////////////////////////
	logic [31:0] m_id_insn;
	logic [31:0] m_ex_insn;
	logic [31:0] m_wb_insn;
	logic [31:0] m_ex_simm;
	logic [2:0] m_id_br;
	logic [2:0] m_ex_br;
	logic m_sel_imm;
	logic [4:0] m_wb_rfaddrw;
	logic [4:0] m_rf_addrw;
	logic [4:0] m_alu_op;
	logic [3:0] m_alu_op2;
	logic [3:0] m_comp_op;
	logic [2:0] m_rfwb_op;
	logic m_illegal;
	logic m_syscall;
	logic m_trap;

	decode_ctrl dut_i (.*);

	bind decode_ctrl decode_ctrl_sva sva_i (
		.clk(clk),
		.reset(reset),
		.flushpipe(flushpipe),
		.ex_bubble(ex_bubble),
		.id_insn(id_insn),
		.ex_insn(ex_insn),
		.wb_insn(wb_insn),
		.id_branch_op(id_branch_op),
		.ex_branch_op(ex_branch_op),
		.alu_op(alu_op),
		.rfwb_op(rfwb_op),
		.except_illegal(except_illegal),
		.sig_syscall(sig_syscall),
		.sig_trap(sig_trap)
	);

	////////////////////////////////////////
	// opcode classes
	////////////////////////////////////////
	function automatic logic known_opcode(input logic [5:0] op);
		return op inside {or32_isa_pkg::OPC_J, or32_isa_pkg::OPC_JAL, or32_isa_pkg::OPC_BNF,
			or32_isa_pkg::OPC_BF, or32_isa_pkg::OPC_NOP, or32_isa_pkg::OPC_MOVHI,
			or32_isa_pkg::OPC_XSYNC, or32_isa_pkg::OPC_RFE, or32_isa_pkg::OPC_JR,
			or32_isa_pkg::OPC_JALR, or32_isa_pkg::OPC_LWZ, or32_isa_pkg::OPC_LWS,
			or32_isa_pkg::OPC_LBZ, or32_isa_pkg::OPC_LBS, or32_isa_pkg::OPC_LHZ,
			or32_isa_pkg::OPC_LHS, or32_isa_pkg::OPC_ADDI, or32_isa_pkg::OPC_ADDIC,
			or32_isa_pkg::OPC_ANDI, or32_isa_pkg::OPC_ORI, or32_isa_pkg::OPC_XORI,
			or32_isa_pkg::OPC_SFXXI, or32_isa_pkg::OPC_SW, or32_isa_pkg::OPC_SB,
			or32_isa_pkg::OPC_SH, or32_isa_pkg::OPC_ALU, or32_isa_pkg::OPC_SFXX};
	endfunction

	function automatic logic is_load(input logic [5:0] op);
		return op inside {or32_isa_pkg::OPC_LWZ, or32_isa_pkg::OPC_LWS, or32_isa_pkg::OPC_LBZ,
			or32_isa_pkg::OPC_LBS, or32_isa_pkg::OPC_LHZ, or32_isa_pkg::OPC_LHS};
	endfunction

	function automatic logic is_store(input logic [5:0] op);
		return op inside {or32_isa_pkg::OPC_SW, or32_isa_pkg::OPC_SB, or32_isa_pkg::OPC_SH};
	endfunction

	////////////////////////////////////////
	// reference decode
	////////////////////////////////////////
	function automatic logic [31:0] ext_imm(input logic [31:0] insn);
		logic [5:0] op;
		op = insn[31:26];
		if (is_load(op) || op inside {or32_isa_pkg::OPC_ADDI, or32_isa_pkg::OPC_ADDIC,
				or32_isa_pkg::OPC_XORI, or32_isa_pkg::OPC_SFXXI})
			return {{16{insn[15]}}, insn[15:0]};
		// store offset is split around rb
		if (is_store(op))
			return {{16{insn[25]}}, insn[25:21], insn[10:0]};
		return {16'h0000, insn[15:0]};
	endfunction

	function automatic logic [2:0] branch_code(input logic [5:0] op);
		if (op == or32_isa_pkg::OPC_J || op == or32_isa_pkg::OPC_JAL)
			return ctrl_pkg::BR_J;
		if (op == or32_isa_pkg::OPC_JR || op == or32_isa_pkg::OPC_JALR)
			return ctrl_pkg::BR_JR;
		if (op == or32_isa_pkg::OPC_BNF)
			return ctrl_pkg::BR_BNF;
		if (op == or32_isa_pkg::OPC_BF)
			return ctrl_pkg::BR_BF;
		if (op == or32_isa_pkg::OPC_RFE)
			return ctrl_pkg::BR_RFE;
		return ctrl_pkg::BR_NOP;
	endfunction

	// rb-reading and immediate-free insns keep operand b on the register file
	function automatic logic imm_select(input logic [5:0] op);
		return !(is_store(op) || op inside {or32_isa_pkg::OPC_JALR, or32_isa_pkg::OPC_JR,
			or32_isa_pkg::OPC_RFE, or32_isa_pkg::OPC_XSYNC, or32_isa_pkg::OPC_ALU,
			or32_isa_pkg::OPC_SFXX, or32_isa_pkg::OPC_NOP});
	endfunction

	function automatic logic [4:0] alu_code(input logic [31:0] insn);
		case (insn[31:26])
			or32_isa_pkg::OPC_MOVHI: return ctrl_pkg::ALUOP_MOVHI;
			or32_isa_pkg::OPC_ADDI: return ctrl_pkg::ALUOP_ADD;
			or32_isa_pkg::OPC_ADDIC: return ctrl_pkg::ALUOP_ADDC;
			or32_isa_pkg::OPC_ANDI: return ctrl_pkg::ALUOP_AND;
			or32_isa_pkg::OPC_ORI: return ctrl_pkg::ALUOP_OR;
			or32_isa_pkg::OPC_XORI: return ctrl_pkg::ALUOP_XOR;
			or32_isa_pkg::OPC_SFXXI, or32_isa_pkg::OPC_SFXX: return ctrl_pkg::ALUOP_COMP;
			or32_isa_pkg::OPC_ALU: return {1'b0, insn[3:0]};
			default: return ctrl_pkg::ALUOP_NOP;
		endcase
	endfunction

	// {source, write enable}
	function automatic logic [2:0] wb_code(input logic [5:0] op);
		if (op == or32_isa_pkg::OPC_JAL || op == or32_isa_pkg::OPC_JALR)
			return {ctrl_pkg::RFWB_LR, 1'b1};
		if (is_load(op))
			return {ctrl_pkg::RFWB_LSU, 1'b1};
		if (op inside {or32_isa_pkg::OPC_MOVHI, or32_isa_pkg::OPC_ADDI, or32_isa_pkg::OPC_ADDIC,
				or32_isa_pkg::OPC_ANDI, or32_isa_pkg::OPC_ORI, or32_isa_pkg::OPC_XORI,
				or32_isa_pkg::OPC_ALU})
			return {ctrl_pkg::RFWB_ALU, 1'b1};
		return ctrl_pkg::RFWB_NOP;
	endfunction

	function automatic logic illegal_insn(input logic [31:0] insn);
		if (insn[31:26] == or32_isa_pkg::OPC_ALU)
			return insn[4:0] inside {or32_isa_pkg::ALU_DIV, or32_isa_pkg::ALU_DIVU,
				or32_isa_pkg::ALU_MUL, or32_isa_pkg::ALU_MULU};
		return !known_opcode(insn[31:26]);
	endfunction

	// EX result first, then WB, then the register file
	function automatic logic [1:0] fwd_sel(input logic [4:0] src);
		if (src == m_rf_addrw && m_rfwb_op[0])
			return ctrl_pkg::SEL_EX_FORW;
		if (src == m_wb_rfaddrw && wbforw_valid)
			return ctrl_pkg::SEL_WB_FORW;
		return ctrl_pkg::SEL_RF;
	endfunction

	////////////////////////////////////////
	// model update on each rising edge
	////////////////////////////////////////
	task automatic clear_ex_model();
		m_alu_op = ctrl_pkg::ALUOP_NOP;
		m_alu_op2 = '0;
		m_comp_op = '0;
		m_rfwb_op = ctrl_pkg::RFWB_NOP;
		m_rf_addrw = '0;
		m_ex_br = ctrl_pkg::BR_NOP;
		m_illegal = 1'b0;
		m_syscall = 1'b0;
		m_trap = 1'b0;
	endtask

	task automatic reset_model();
		m_id_insn = `NOP_INSN;
		m_ex_insn = `NOP_INSN;
		m_wb_insn = `NOP_INSN;
		m_ex_simm = '0;
		m_id_br = ctrl_pkg::BR_NOP;
		m_sel_imm = 1'b0;
		m_wb_rfaddrw = '0;
		clear_ex_model();
	endtask

	// later stages first so each reads the old value of the stage before
	task automatic step_model();
		logic flush;
		logic bubble;
		flush = except_flushpipe | pc_we | extend_flush | du_flush_pipe;
		bubble = flush | (!ex_freeze & id_freeze);
		if (!wb_freeze) begin
			m_wb_insn = m_ex_insn;
			m_wb_rfaddrw = m_rf_addrw;
		end
		if (!ex_freeze)
			m_ex_simm = ext_imm(m_id_insn);
		if (bubble) begin
			m_ex_insn = `NOP_INSN;
			clear_ex_model();
		end else if (!ex_freeze) begin
			m_ex_insn = m_id_insn;
			m_alu_op = alu_code(m_id_insn);
			m_alu_op2 = m_id_insn[9:6];
			m_comp_op = m_id_insn[24:21];
			m_rfwb_op = wb_code(m_id_insn[31:26]);
			m_rf_addrw = m_rfwb_op[2:1] == ctrl_pkg::RFWB_LR ? `LINK_REG : m_id_insn[25:21];
			m_ex_br = m_id_br;
			m_illegal = illegal_insn(m_id_insn);
			m_syscall = m_id_insn[31:23] == {or32_isa_pkg::OPC_XSYNC, 3'b000};
			m_trap = (m_id_insn[31:23] == {or32_isa_pkg::OPC_XSYNC, 3'b010}) | du_hwbkpt;
		end
		if (!id_freeze)
			m_sel_imm = imm_select(if_insn[31:26]);
		if (flush) begin
			m_id_insn = `NOP_INSN;
			m_id_br = ctrl_pkg::BR_NOP;
		end else if (!id_freeze) begin
			m_id_insn = if_insn;
			m_id_br = branch_code(if_insn[31:26]);
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	// mostly known opcodes with operands often squeezed to r0..r3 so forwarding hits
	function automatic logic [31:0] make_insn();
		logic [31:0] w;
		logic [5:0] op;
		w = $urandom;
		op = 6'($urandom);
		if (($urandom % 8) != 0) begin
			repeat (64) if (!known_opcode(op)) op = 6'($urandom);
		end
		if (($urandom % 2) == 0) begin
			w[25:21] = 5'($urandom % 4);
			w[20:16] = 5'($urandom % 4);
			w[15:11] = 5'($urandom % 4);
		end
		w[31:26] = op;
		return w;
	endfunction

	task automatic drive_inputs();
		wb_freeze = ($urandom % 12) == 0;
		ex_freeze = wb_freeze | (($urandom % 10) == 0);
		id_freeze = ex_freeze | (($urandom % 8) == 0);
		except_flushpipe = ($urandom % 60) == 0;
		pc_we = ($urandom % 50) == 0;
		extend_flush = ($urandom % 80) == 0;
		du_flush_pipe = ($urandom % 80) == 0;
		du_hwbkpt = ($urandom % 40) == 0;
		wbforw_valid = 1'($urandom);
		ex_branch_taken = 1'($urandom);
		if_insn = make_insn();
	endtask

	////////////////////////////////////////
	// checking
	////////////////////////////////////////
	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		error_count++;
		$display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
		$display("Result: FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else report_mismatch(name, got, exp);
	endtask

	task automatic check_outputs();
		logic [1:0] exp_sel_b;
		logic exp_rfe;
		exp_sel_b = m_sel_imm ? ctrl_pkg::SEL_IMM : fwd_sel(m_id_insn[15:11]);
		exp_rfe = (m_id_br == ctrl_pkg::BR_RFE) || (m_ex_br == ctrl_pkg::BR_RFE);
		check_value("id_insn", id_insn, m_id_insn);
		check_value("ex_insn", ex_insn, m_ex_insn);
		check_value("wb_insn", wb_insn, m_wb_insn);
		check_value("id_simm", id_simm, ext_imm(m_id_insn));
		check_value("ex_simm", ex_simm, m_ex_simm);
		check_value("rf_addra", 32'(rf_addra), 32'(if_insn[20:16]));
		check_value("rf_addrb", 32'(rf_addrb), 32'(if_insn[15:11]));
		check_value("rf_rda", 32'(rf_rda), 32'(if_insn[31]));
		check_value("rf_rdb", 32'(rf_rdb), 32'(if_insn[30]));
		check_value("sel_a", 32'(sel_a), 32'(fwd_sel(m_id_insn[20:16])));
		check_value("sel_b", 32'(sel_b), 32'(exp_sel_b));
		check_value("id_branch_op", 32'(id_branch_op), 32'(m_id_br));
		check_value("ex_branch_op", 32'(ex_branch_op), 32'(m_ex_br));
		check_value("alu_op", 32'(alu_op), 32'(m_alu_op));
		check_value("alu_op2", 32'(alu_op2), 32'(m_alu_op2));
		check_value("comp_op", 32'(comp_op), 32'(m_comp_op));
		check_value("rfwb_op", 32'(rfwb_op), 32'(m_rfwb_op));
		check_value("rf_addrw", 32'(rf_addrw), 32'(m_rf_addrw));
		check_value("except_illegal", 32'(except_illegal), 32'(m_illegal));
		check_value("sig_syscall", 32'(sig_syscall), 32'(m_syscall));
		check_value("sig_trap", 32'(sig_trap), 32'(m_trap));
		check_value("rfe", 32'(rfe), 32'(exp_rfe));
		check_value("flushpipe", 32'(flushpipe),
			32'(except_flushpipe | pc_we | extend_flush | du_flush_pipe));
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// guard against a stalled run
	initial begin : watchdog
		int waited;
		waited = 0;
		while (waited < RUN_CYCLES + 100) begin
			@(posedge clk);
			waited++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", RUN_CYCLES + 100);
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(SEED));
		error_count = 0;
		reset = 1'b1;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		except_flushpipe = 1'b0;
		pc_we = 1'b0;
		extend_flush = 1'b0;
		du_flush_pipe = 1'b0;
		if_insn = `NOP_INSN;
		wbforw_valid = 1'b0;
		du_hwbkpt = 1'b0;
		ex_branch_taken = 1'b0;
		reset_model();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		drive_inputs();
		#1;
		check_outputs();
		// inputs change 1 ns after the edge and outputs are compared 1 ns later
		for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			@(posedge clk);
			step_model();
			#1;
			drive_inputs();
			#1;
			check_outputs();
		end
		if (error_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "%0d mismatches", error_count);
		end
	end

endmodule

`default_nettype wire

// File: verilog/ctrl_pkg.sv
////////////////////////////////////////
// control codes passed from decode to the datapath
////////////////////////////////////////
`default_nettype none

package ctrl_pkg;

	// EX ALU operation
	typedef logic [4:0] alu_op_t;
	localparam alu_op_t ALUOP_ADD   = 5'b0_0000;
	localparam alu_op_t ALUOP_ADDC  = 5'b0_0001;
	localparam alu_op_t ALUOP_AND   = 5'b0_0011;
	localparam alu_op_t ALUOP_OR    = 5'b0_0100;
	localparam alu_op_t ALUOP_XOR   = 5'b0_0101;
	localparam alu_op_t ALUOP_MOVHI = 5'b1_0000;
	localparam alu_op_t ALUOP_COMP  = 5'b1_0001;
	// nop shares the OR code, its result is never written back
	localparam alu_op_t ALUOP_NOP   = 5'b0_0100;

	// shift/rotate sub-op and compare condition
	typedef logic [3:0] alu_op2_t;
	typedef logic [3:0] comp_op_t;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BF  = 3'd4,
		BR_BNF = 3'd5,
		BR_RFE = 3'd6
	} branch_op_e;

	// operand mux selects
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

	// writeback op is {source, write enable}
	typedef logic [2:0] rfwb_op_t;
	typedef logic [1:0] rfwb_src_t;
	localparam rfwb_src_t RFWB_ALU = 2'b00;
	localparam rfwb_src_t RFWB_LSU = 2'b01;
	localparam rfwb_src_t RFWB_LR  = 2'b11;
	localparam rfwb_op_t RFWB_NOP  = 3'b000;

endpackage

`default_nettype wire

// File: verilog/decode_config.svh
////////////////////////////////////////
// fixed widths and words of the OR32 decode path
// NOP_INSN refers to or32_isa_pkg, so compile that package first
////////////////////////////////////////
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// instruction word and immediate width
`define INSN_W 32
`define IMM_W 32

// register file address width
`define RF_ADDR_W 5

// r9 takes the return address of l.jal and l.jalr
`define LINK_REG 5'd9

// filler nop, bit 16 set marks it as pipeline-generated
`define NOP_INSN {or32_isa_pkg::OPC_NOP, 26'h041_0000}

// sub-opcode in insn[25:23] of the xsync group
`define SYS_SUBOP 3'b000
`define TRAP_SUBOP 3'b010

`endif

// File: verilog/decode_ctrl.sv
////////////////////////////////////////
// decode control of a 5-stage OR32 pipe
// freezes must nest, wb implies ex implies id
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module decode_ctrl (
	input wire logic clk,
	input wire logic reset,
	// stall levels
	input wire logic id_freeze,
	input wire logic ex_freeze,
	input wire logic wb_freeze,
	// flush sources
	input wire logic except_flushpipe,
	input wire logic pc_we,
	input wire logic extend_flush,
	input wire logic du_flush_pipe,
	input wire or32_isa_pkg::insn_t if_insn,
	input wire logic wbforw_valid,
	input wire logic du_hwbkpt,
	// branch outcome, kept on the port for the rfe path
	input wire logic ex_branch_taken,
	output or32_isa_pkg::insn_t id_insn,
	output or32_isa_pkg::insn_t ex_insn,
	output or32_isa_pkg::insn_t wb_insn,
	output or32_isa_pkg::imm_t id_simm,
	output or32_isa_pkg::imm_t ex_simm,
	output or32_isa_pkg::rf_addr_t rf_addra,
	output or32_isa_pkg::rf_addr_t rf_addrb,
	output or32_isa_pkg::rf_addr_t rf_addrw,
	output logic rf_rda,
	output logic rf_rdb,
	output ctrl_pkg::sel_e sel_a,
	output ctrl_pkg::sel_e sel_b,
	output ctrl_pkg::branch_op_e id_branch_op,
	output ctrl_pkg::branch_op_e ex_branch_op,
	output ctrl_pkg::alu_op_t alu_op,
	output ctrl_pkg::alu_op2_t alu_op2,
	output ctrl_pkg::comp_op_t comp_op,
	output ctrl_pkg::rfwb_op_t rfwb_op,
	output logic except_illegal,
	output logic sig_syscall,
	output logic sig_trap,
	output logic rfe,
	output logic flushpipe
);

	// EX stage nop insertion
	logic ex_bubble;
	// registered immediate select for operand b
	logic sel_imm;

	insn_pipe insn_pipe_i (.*);

	if_predecode if_predecode_i (.*);

	imm_extend imm_extend_i (.*);

	operand_select operand_select_i (.*);

	ex_decode ex_decode_i (.*);

endmodule

`default_nettype wire

// File: verilog/ex_decode.sv
////////////////////////////////////////
// EX control fields, decoded from id_insn
// mul/div functions have no unit and trap as illegal
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "decode_config.svh"

module ex_decode (
	input wire logic clk,
	input wire logic reset,
	input wire or32_isa_pkg::insn_t id_insn,
	input wire ctrl_pkg::branch_op_e id_branch_op,
	input wire logic ex_bubble,
	input wire logic ex_freeze,
	input wire logic du_hwbkpt,
	output ctrl_pkg::alu_op_t alu_op,
	output ctrl_pkg::alu_op2_t alu_op2,
	output ctrl_pkg::comp_op_t comp_op,
	output ctrl_pkg::rfwb_op_t rfwb_op,
	output or32_isa_pkg::rf_addr_t rf_addrw,
	output ctrl_pkg::branch_op_e ex_branch_op,
	output logic except_illegal,
	output logic sig_syscall,
	output logic sig_trap,
	output logic rfe
);

	// ALU function field of id_insn
	or32_isa_pkg::alu_func_t alu_func;

	assign alu_func = id_insn[4:0];

	// rfe seen in either ID or EX
	assign rfe = (id_branch_op == ctrl_pkg::BR_RFE) | (ex_branch_op == ctrl_pkg::BR_RFE);

	////////////////////////////////////////
	// EX field registers
	////////////////////////////////////////
	// a bubble covers flushes and the ID stall, rf_addrw goes to r0 there too
	always_ff @(posedge clk) begin
		if (reset || ex_bubble) begin
			alu_op <= ctrl_pkg::ALUOP_NOP;
			alu_op2 <= '0;
			comp_op <= '0;
			rfwb_op <= ctrl_pkg::RFWB_NOP;
			rf_addrw <= '0;
			ex_branch_op <= ctrl_pkg::BR_NOP;
			except_illegal <= 1'b0;
			sig_syscall <= 1'b0;
			sig_trap <= 1'b0;
		end else if (!ex_freeze) begin
			alu_op2 <= id_insn[9:6];
			comp_op <= id_insn[24:21];
			ex_branch_op <= id_branch_op;
			// l.sys and l.trap share the xsync opcode
			sig_syscall <= (id_insn[31:23] == {or32_isa_pkg::OPC_XSYNC, `SYS_SUBOP});
			sig_trap <= (id_insn[31:23] == {or32_isa_pkg::OPC_XSYNC, `TRAP_SUBOP})
				| du_hwbkpt;

			// alu operation
			case (id_insn[31:26])
				or32_isa_pkg::OPC_MOVHI: alu_op <= ctrl_pkg::ALUOP_MOVHI;
				or32_isa_pkg::OPC_ADDI:  alu_op <= ctrl_pkg::ALUOP_ADD;
				or32_isa_pkg::OPC_ADDIC: alu_op <= ctrl_pkg::ALUOP_ADDC;
				or32_isa_pkg::OPC_ANDI:  alu_op <= ctrl_pkg::ALUOP_AND;
				or32_isa_pkg::OPC_ORI:   alu_op <= ctrl_pkg::ALUOP_OR;
				or32_isa_pkg::OPC_XORI:  alu_op <= ctrl_pkg::ALUOP_XOR;
				or32_isa_pkg::OPC_SFXXI, or32_isa_pkg::OPC_SFXX:
					alu_op <= ctrl_pkg::ALUOP_COMP;
				or32_isa_pkg::OPC_ALU:   alu_op <= {1'b0, id_insn[3:0]};
				default:                 alu_op <= ctrl_pkg::ALUOP_NOP;
			endcase

			// writeback source and destination
			rf_addrw <= id_insn[25:21];
			case (id_insn[31:26])
				or32_isa_pkg::OPC_JAL, or32_isa_pkg::OPC_JALR: begin
					rfwb_op <= {ctrl_pkg::RFWB_LR, 1'b1};
					rf_addrw <= `LINK_REG;
				end
				or32_isa_pkg::OPC_LWZ, or32_isa_pkg::OPC_LWS,
				or32_isa_pkg::OPC_LBZ, or32_isa_pkg::OPC_LBS,
				or32_isa_pkg::OPC_LHZ, or32_isa_pkg::OPC_LHS:
					rfwb_op <= {ctrl_pkg::RFWB_LSU, 1'b1};
				or32_isa_pkg::OPC_MOVHI, or32_isa_pkg::OPC_ADDI,
				or32_isa_pkg::OPC_ADDIC, or32_isa_pkg::OPC_ANDI,
				or32_isa_pkg::OPC_ORI, or32_isa_pkg::OPC_XORI,
				or32_isa_pkg::OPC_ALU:
					rfwb_op <= {ctrl_pkg::RFWB_ALU, 1'b1};
				default:
					rfwb_op <= ctrl_pkg::RFWB_NOP;
			endcase

			// anything outside the supported opcode set is illegal
			case (id_insn[31:26])
				or32_isa_pkg::OPC_J, or32_isa_pkg::OPC_JAL, or32_isa_pkg::OPC_BNF,
				or32_isa_pkg::OPC_BF, or32_isa_pkg::OPC_NOP, or32_isa_pkg::OPC_MOVHI,
				or32_isa_pkg::OPC_XSYNC, or32_isa_pkg::OPC_RFE, or32_isa_pkg::OPC_JR,
				or32_isa_pkg::OPC_JALR, or32_isa_pkg::OPC_LWZ, or32_isa_pkg::OPC_LWS,
				or32_isa_pkg::OPC_LBZ, or32_isa_pkg::OPC_LBS, or32_isa_pkg::OPC_LHZ,
				or32_isa_pkg::OPC_LHS, or32_isa_pkg::OPC_ADDI, or32_isa_pkg::OPC_ADDIC,
				or32_isa_pkg::OPC_ANDI, or32_isa_pkg::OPC_ORI, or32_isa_pkg::OPC_XORI,
				or32_isa_pkg::OPC_SFXXI, or32_isa_pkg::OPC_SW, or32_isa_pkg::OPC_SB,
				or32_isa_pkg::OPC_SH, or32_isa_pkg::OPC_SFXX:
					except_illegal <= 1'b0;
				or32_isa_pkg::OPC_ALU:
					except_illegal <= (alu_func == or32_isa_pkg::ALU_DIV)
						| (alu_func == or32_isa_pkg::ALU_DIVU)
						| (alu_func == or32_isa_pkg::ALU_MUL)
						| (alu_func == or32_isa_pkg::ALU_MULU);
				default:
					except_illegal <= 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/if_predecode.sv
////////////////////////////////////////
// fetch-side decode, lines up with id_insn
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module if_predecode (
	input wire logic clk,
	input wire logic reset,
	input wire or32_isa_pkg::insn_t if_insn,
	input wire logic id_freeze,
	input wire logic flushpipe,
	output ctrl_pkg::branch_op_e id_branch_op,
	output logic sel_imm
);

	// branch type of the word entering ID
	always_ff @(posedge clk) begin
		if (reset || flushpipe) begin
			id_branch_op <= ctrl_pkg::BR_NOP;
		end else if (!id_freeze) begin
			case (if_insn[31:26])
				or32_isa_pkg::OPC_J, or32_isa_pkg::OPC_JAL:
					id_branch_op <= ctrl_pkg::BR_J;
				or32_isa_pkg::OPC_JR, or32_isa_pkg::OPC_JALR:
					id_branch_op <= ctrl_pkg::BR_JR;
				or32_isa_pkg::OPC_BNF:
					id_branch_op <= ctrl_pkg::BR_BNF;
				or32_isa_pkg::OPC_BF:
					id_branch_op <= ctrl_pkg::BR_BF;
				or32_isa_pkg::OPC_RFE:
					id_branch_op <= ctrl_pkg::BR_RFE;
				default:
					id_branch_op <= ctrl_pkg::BR_NOP;
			endcase
		end
	end

	// operand b from the immediate unless the insn reads rb or has no imm
	// not cleared by flush, a flushed slot holds a nop anyway
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_imm <= 1'b0;
		end else if (!id_freeze) begin
			case (if_insn[31:26])
				or32_isa_pkg::OPC_JALR, or32_isa_pkg::OPC_JR, or32_isa_pkg::OPC_RFE,
				or32_isa_pkg::OPC_XSYNC, or32_isa_pkg::OPC_SW, or32_isa_pkg::OPC_SB,
				or32_isa_pkg::OPC_SH, or32_isa_pkg::OPC_ALU, or32_isa_pkg::OPC_SFXX,
				or32_isa_pkg::OPC_NOP:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/imm_extend.sv
////////////////////////////////////////
// ID immediate extension and its EX copy
// ex_simm ignores bubbles, only ex_freeze holds it
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module imm_extend (
	input wire logic clk,
	input wire logic reset,
	input wire or32_isa_pkg::insn_t id_insn,
	input wire logic ex_freeze,
	output or32_isa_pkg::imm_t id_simm,
	output or32_isa_pkg::imm_t ex_simm
);

	always_comb begin
		case (id_insn[31:26])
			// signed 16-bit immediate
			or32_isa_pkg::OPC_ADDI, or32_isa_pkg::OPC_ADDIC,
			or32_isa_pkg::OPC_LWZ, or32_isa_pkg::OPC_LWS,
			or32_isa_pkg::OPC_LBZ, or32_isa_pkg::OPC_LBS,
			or32_isa_pkg::OPC_LHZ, or32_isa_pkg::OPC_LHS,
			or32_isa_pkg::OPC_XORI, or32_isa_pkg::OPC_SFXXI:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// stores split the offset around the rb field
			or32_isa_pkg::OPC_SW, or32_isa_pkg::OPC_SB, or32_isa_pkg::OPC_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			// logic ops and the rest zero extend
			default:
				id_simm = {16'h0000, id_insn[15:0]};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_simm <= '0;
		end else if (!ex_freeze) begin
			ex_simm <= id_simm;
		end
	end

endmodule

`default_nettype wire

// File: verilog/insn_pipe.sv
////////////////////////////////////////
// ID, EX and WB instruction latches
// WB keeps its word through flushes
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "decode_config.svh"

module insn_pipe (
	input wire logic clk,
	input wire logic reset,
	input wire or32_isa_pkg::insn_t if_insn,
	input wire logic id_freeze,
	input wire logic ex_freeze,
	input wire logic wb_freeze,
	input wire logic except_flushpipe,
	input wire logic pc_we,
	input wire logic extend_flush,
	input wire logic du_flush_pipe,
	output or32_isa_pkg::insn_t id_insn,
	output or32_isa_pkg::insn_t ex_insn,
	output or32_isa_pkg::insn_t wb_insn,
	output logic flushpipe,
	output logic ex_bubble
);

	// all flush sources hit every stage alike
	assign flushpipe = except_flushpipe | pc_we | extend_flush | du_flush_pipe;

	// EX takes a nop on flush, or when ID stalls and EX moves on
	assign ex_bubble = flushpipe | (!ex_freeze & id_freeze);

	// ID latch, flush wins over freeze
	always_ff @(posedge clk) begin
		if (reset || flushpipe) begin
			id_insn <= `NOP_INSN;
		end else if (!id_freeze) begin
			id_insn <= if_insn;
		end
	end

	// EX latch
	always_ff @(posedge clk) begin
		if (reset || ex_bubble) begin
			ex_insn <= `NOP_INSN;
		end else if (!ex_freeze) begin
			ex_insn <= id_insn;
		end
	end

	// WB latch follows EX, only a freeze holds it
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_insn <= `NOP_INSN;
		end else if (!wb_freeze) begin
			wb_insn <= ex_insn;
		end
	end

endmodule

`default_nettype wire

// File: verilog/operand_select.sv
////////////////////////////////////////
// register read ports and forwarding selects
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module operand_select (
	input wire logic clk,
	input wire logic reset,
	input wire or32_isa_pkg::insn_t if_insn,
	input wire or32_isa_pkg::insn_t id_insn,
	input wire logic sel_imm,
	input wire or32_isa_pkg::rf_addr_t rf_addrw,
	input wire ctrl_pkg::rfwb_op_t rfwb_op,
	input wire logic wbforw_valid,
	input wire logic wb_freeze,
	output or32_isa_pkg::rf_addr_t rf_addra,
	output or32_isa_pkg::rf_addr_t rf_addrb,
	output logic rf_rda,
	output logic rf_rdb,
	output ctrl_pkg::sel_e sel_a,
	output ctrl_pkg::sel_e sel_b
);

	// write address of the insn now in WB
	or32_isa_pkg::rf_addr_t wb_rfaddrw;

	// read ports address from the fetched word
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];
	assign rf_rda = if_insn[31];
	assign rf_rdb = if_insn[30];

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_rfaddrw <= '0;
		end else if (!wb_freeze) begin
			wb_rfaddrw <= rf_addrw;
		end
	end

	// EX result is newer than WB, so it wins
	always_comb begin
		if ((id_insn[20:16] == rf_addrw) && rfwb_op[0])
			sel_a = ctrl_pkg::SEL_EX_FORW;
		else if ((id_insn[20:16] == wb_rfaddrw) && wbforw_valid)
			sel_a = ctrl_pkg::SEL_WB_FORW;
		else
			sel_a = ctrl_pkg::SEL_RF;
	end

	always_comb begin
		if (sel_imm)
			sel_b = ctrl_pkg::SEL_IMM;
		else if ((id_insn[15:11] == rf_addrw) && rfwb_op[0])
			sel_b = ctrl_pkg::SEL_EX_FORW;
		else if ((id_insn[15:11] == wb_rfaddrw) && wbforw_valid)
			sel_b = ctrl_pkg::SEL_WB_FORW;
		else
			sel_b = ctrl_pkg::SEL_RF;
	end

endmodule

`default_nettype wire

// File: verilog/or32_isa_pkg.sv
////////////////////////////////////////
// OR32 instruction set encodings
// only the opcodes this decoder accepts are listed
////////////////////////////////////////
`default_nettype none
`include "decode_config.svh"

package or32_isa_pkg;

	// field widths inside the instruction word
	localparam int OPCODE_W = 6;
	localparam int ALU_FUNC_W = 5;

	typedef logic [`INSN_W-1:0] insn_t;
	typedef logic [`RF_ADDR_W-1:0] rf_addr_t;
	typedef logic [`IMM_W-1:0] imm_t;

	// ALU function code sits in insn[4:0]
	typedef logic [ALU_FUNC_W-1:0] alu_func_t;

	// major opcode in insn[31:26]
	typedef enum logic [OPCODE_W-1:0] {
		OPC_J     = 6'h00,
		OPC_JAL   = 6'h01,
		OPC_BNF   = 6'h03,
		OPC_BF    = 6'h04,
		OPC_NOP   = 6'h05,
		OPC_MOVHI = 6'h06,
		OPC_XSYNC = 6'h08,
		OPC_RFE   = 6'h09,
		OPC_JR    = 6'h11,
		OPC_JALR  = 6'h12,
		OPC_LWZ   = 6'h21,
		OPC_LWS   = 6'h22,
		OPC_LBZ   = 6'h23,
		OPC_LBS   = 6'h24,
		OPC_LHZ   = 6'h25,
		OPC_LHS   = 6'h26,
		OPC_ADDI  = 6'h27,
		OPC_ADDIC = 6'h28,
		OPC_ANDI  = 6'h29,
		OPC_ORI   = 6'h2a,
		OPC_XORI  = 6'h2b,
		OPC_SFXXI = 6'h2f,
		OPC_SW    = 6'h35,
		OPC_SB    = 6'h36,
		OPC_SH    = 6'h37,
		OPC_ALU   = 6'h38,
		OPC_SFXX  = 6'h39
	} opcode_e;

	// multiply and divide functions, no unit behind them here
	localparam alu_func_t ALU_MUL  = 5'h06;
	localparam alu_func_t ALU_DIV  = 5'h09;
	localparam alu_func_t ALU_DIVU = 5'h0a;
	localparam alu_func_t ALU_MULU = 5'h0b;

endpackage

`default_nettype wire
